// ==== common/div_pkg.sv ====
package div_pkg;

  // Dividend width
  localparam int n_width = 16;

  // Divisor, quotient and remainder width
  localparam int d_width = 8;

  // Results reported when the quotient does not fit
  localparam logic [d_width-1:0] ovf_quotient = '1;
  localparam logic [d_width-1:0] ovf_remainder = '0;

endpackage

// ==== common/cfg_pkg.sv ====
package cfg_pkg;

  localparam int addr_width = 2;

  // Register map
  localparam logic [addr_width-1:0] addr_mode = 2'd0;
  localparam logic [addr_width-1:0] addr_op_count = 2'd1;
  localparam logic [addr_width-1:0] addr_ovf_count = 2'd2;
  localparam logic [addr_width-1:0] addr_mismatch_count = 2'd3;

  // Bit 0 of the mode register
  localparam logic mode_exact = 1'b0;
  localparam logic mode_approx = 1'b1;

  // Counter and register data width
  localparam int cnt_width = 16;

endpackage

// ==== common/div_stat_if.sv ====
`timescale 1ns/1ps

interface div_stat_if;

  // Result select, from the register block
  logic mode_approx;

  // One pulse per result loaded, with its flags
  logic done;
  logic done_ovf;
  logic done_mismatch;

  modport src (
    input  mode_approx,
    output done,
    output done_ovf,
    output done_mismatch
  );

  modport dst (
    output mode_approx,
    input  done,
    input  done_ovf,
    input  done_mismatch
  );

endinterface

// ==== approx_divider/approx_div_cells.sv ====
`timescale 1ns/1ps

module subtractor (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  assign diff = x ^ y ^ bin;
  assign bout = (~x & y) | (~(x ^ y) & bin);
  // Restoring step keeps x when the row did not subtract
  assign r_sub = qs ? diff : x;

endmodule

module approx_sub_cell (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  // Reduced logic, wrong on some input combinations
  assign bout = (~x & y) | (x & y & bin);
  assign diff = (x & ~y & ~bin) | (x & y & bin);
  assign r_sub = qs ? diff : x;

endmodule

// ==== approx_divider/divider_array_triangular.sv ====
`timescale 1ns/1ps

module divider_array_triangular #(
  parameter int approx_depth = 6
) (
  input  logic [div_pkg::n_width-1:0] n,
  input  logic [div_pkg::d_width-1:0] d,
  output logic [div_pkg::d_width-1:0] q,
  output logic [div_pkg::d_width-1:0] r
);
  import div_pkg::*;

  // Partial remainder and borrow of row k, column j
  wire [d_width-1:0] rem [d_width];
  wire [d_width-1:0] bor [d_width];
  wire [d_width-1:0] q_bit;

  // Rows run from the quotient MSB (k = d_width-1) down to bit 0
  for (genvar k = 0; k < d_width; k++) begin : g_row
    wire top_bit;

    if (k == d_width - 1) begin : g_top_first
      assign top_bit = n[n_width-1];
    end else begin : g_top_inner
      assign top_bit = rem[k+1][d_width-1];
    end

    // Subtract succeeded, or the shifted remainder already exceeds d
    assign q_bit[k] = top_bit | ~bor[k][d_width-1];

    for (genvar j = 0; j < d_width; j++) begin : g_col
      wire x_in;
      wire b_in;

      if (j == 0) begin : g_lsb
        // Next dividend bit enters at the bottom of each row
        assign x_in = n[k];
        assign b_in = 1'b0;
      end else if (k == d_width - 1) begin : g_first_row
        assign x_in = n[k+j];
        assign b_in = bor[k][j-1];
      end else begin : g_inner
        assign x_in = rem[k+1][j-1];
        assign b_in = bor[k][j-1];
      end

      // Triangle near the LSB corner
      if (k + j < approx_depth) begin : g_apx
        approx_sub_cell i_cell (
          .x     (x_in),
          .y     (d[j]),
          .bin   (b_in),
          .qs    (q_bit[k]),
          .r_sub (rem[k][j]),
          .bout  (bor[k][j])
        );
      end else begin : g_ext
        subtractor i_cell (
          .x     (x_in),
          .y     (d[j]),
          .bin   (b_in),
          .qs    (q_bit[k]),
          .r_sub (rem[k][j]),
          .bout  (bor[k][j])
        );
      end
    end
  end

  assign q = q_bit;
  assign r = rem[0];

endmodule

// ==== verilog/div_pipe.sv ====
`timescale 1ns/1ps

module div_pipe #(
  parameter int approx_depth = 6
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  logic [div_pkg::n_width-1:0] n,
  input  logic [div_pkg::d_width-1:0] d,
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic [div_pkg::d_width-1:0] q,
  output logic [div_pkg::d_width-1:0] r,
  output logic                        ovf,
  div_stat_if.src                     stat
);
  import div_pkg::*;

  logic started;
  logic accept;
  logic advance;
  logic mismatch;

  logic               op_valid;
  logic [n_width-1:0] op_n;
  logic [d_width-1:0] op_d;
  logic               op_ovf;

  logic               res_valid;
  logic [d_width-1:0] res_q;
  logic [d_width-1:0] res_r;
  logic               res_ovf;

  logic [d_width-1:0] q_apx;
  logic [d_width-1:0] r_apx;
  logic [d_width-1:0] q_ext;
  logic [d_width-1:0] r_ext;

  divider_array_triangular #(.approx_depth(approx_depth)) i_array_apx (
    .n (op_n),
    .d (op_d),
    .q (q_apx),
    .r (r_apx)
  );

  divider_array_triangular #(.approx_depth(0)) i_array_ext (
    .n (op_n),
    .d (op_d),
    .q (q_ext),
    .r (r_ext)
  );

  // Result stage free, or draining this cycle
  assign advance = op_valid && (!res_valid || out_ready);
  assign in_ready = started && (!op_valid || advance);
  assign accept = in_valid && in_ready;
  assign mismatch = (q_apx != q_ext) || (r_apx != r_ext);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      started <= 1'b0;
      op_valid <= 1'b0;
      res_valid <= 1'b0;
      stat.done <= 1'b0;
      stat.done_ovf <= 1'b0;
      stat.done_mismatch <= 1'b0;
    end else begin
      started <= 1'b1;
      if (accept) begin
        op_valid <= 1'b1;
      end else if (advance) begin
        op_valid <= 1'b0;
      end
      if (advance) begin
        res_valid <= 1'b1;
      end else if (out_ready) begin
        res_valid <= 1'b0;
      end
      stat.done <= advance;
      stat.done_ovf <= advance && op_ovf;
      stat.done_mismatch <= advance && !op_ovf && mismatch;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_n <= n;
      op_d <= d;
      // Quotient fits in d_width bits only if the high half is below d
      op_ovf <= (n[n_width-1 -: d_width] >= d);
    end
    if (advance) begin
      res_ovf <= op_ovf;
      if (op_ovf) begin
        res_q <= ovf_quotient;
        res_r <= ovf_remainder;
      end else if (stat.mode_approx) begin
        res_q <= q_apx;
        res_r <= r_apx;
      end else begin
        res_q <= q_ext;
        res_r <= r_ext;
      end
    end
  end

  assign out_valid = res_valid;
  assign q = res_q;
  assign r = res_r;
  assign ovf = res_ovf;

endmodule

// ==== verilog/div_cfg_regs.sv ====
`timescale 1ns/1ps

module div_cfg_regs (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           cfg_wr,
  input  logic                           cfg_rd,
  input  logic [cfg_pkg::addr_width-1:0] cfg_addr,
  input  logic [cfg_pkg::cnt_width-1:0]  cfg_wdata,
  output logic [cfg_pkg::cnt_width-1:0]  cfg_rdata,
  div_stat_if.dst                        stat
);
  import cfg_pkg::*;

  localparam int n_cnt = 3;

  logic                 mode_q;
  logic [cnt_width-1:0] cnt [n_cnt];
  logic [n_cnt-1:0]     cnt_inc;
  logic [n_cnt-1:0]     cnt_clr;
  logic [cnt_width-1:0] rd_mux;

  assign stat.mode_approx = (mode_q == mode_approx);

  // Index 0 operations, 1 overflows, 2 mismatches
  assign cnt_inc = {stat.done && stat.done_mismatch, stat.done && stat.done_ovf, stat.done};
  assign cnt_clr = {cfg_wr && (cfg_addr == addr_mismatch_count),
                    cfg_wr && (cfg_addr == addr_ovf_count),
                    cfg_wr && (cfg_addr == addr_op_count)};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mode_q <= mode_exact;
    end else if (cfg_wr && (cfg_addr == addr_mode)) begin
      mode_q <= cfg_wdata[0];
    end
  end

  for (genvar i = 0; i < n_cnt; i++) begin : g_cnt
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        cnt[i] <= '0;
      end else if (cnt_clr[i]) begin
        cnt[i] <= '0;
      end else if (cnt_inc[i] && (cnt[i] != '1)) begin
        // Saturate at all ones
        cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      addr_mode:      rd_mux = {{(cnt_width-1){1'b0}}, mode_q};
      addr_op_count:  rd_mux = cnt[0];
      addr_ovf_count: rd_mux = cnt[1];
      default:        rd_mux = cnt[2];
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg_rdata <= '0;
    end else if (cfg_rd) begin
      cfg_rdata <= rd_mux;
    end
  end

endmodule

// ==== verilog/approx_div_top.sv ====
`timescale 1ns/1ps

module approx_div_top #(
  parameter int approx_depth = 6
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [div_pkg::n_width-1:0]    n,
  input  logic [div_pkg::d_width-1:0]    d,
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [div_pkg::d_width-1:0]    q,
  output logic [div_pkg::d_width-1:0]    r,
  output logic                           ovf,
  input  logic                           cfg_wr,
  input  logic                           cfg_rd,
  input  logic [cfg_pkg::addr_width-1:0] cfg_addr,
  input  logic [cfg_pkg::cnt_width-1:0]  cfg_wdata,
  output logic [cfg_pkg::cnt_width-1:0]  cfg_rdata
);

  // Mode out to the pipe, completion events back
  div_stat_if stat_if ();

  div_pipe #(.approx_depth(approx_depth)) i_div_pipe (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .n         (n),
    .d         (d),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .q         (q),
    .r         (r),
    .ovf       (ovf),
    .stat      (stat_if.src)
  );

  div_cfg_regs i_div_cfg_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .stat      (stat_if.dst)
  );

endmodule

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
  parameter int period_ns = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(period_ns / 2) clk = ~clk;

endmodule

// ==== verif/approx_div_sva.sv ====
`timescale 1ns/1ps

module approx_div_sva (
  input logic                        clk,
  input logic                        arst_n,
  input logic                        in_valid,
  input logic                        in_ready,
  input logic [div_pkg::n_width-1:0] n,
  input logic [div_pkg::d_width-1:0] d,
  input logic                        out_valid,
  input logic                        out_ready,
  input logic [div_pkg::d_width-1:0] q,
  input logic [div_pkg::d_width-1:0] r,
  input logic                        ovf
);

  int failures = 0;

  // Result held while the sink stalls
  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable({q, r, ovf}))
    else begin
      failures++;
      $error("output changed while out_ready was low");
    end

  a_in_hold: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && !in_ready |=> in_valid && $stable({n, d}))
    else begin
      failures++;
      $error("input changed while in_ready was low");
    end

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> !out_valid && !in_ready)
    else begin
      failures++;
      $error("handshake outputs active during reset");
    end

  // First cycle out of reset stays quiet and then the pipe opens
  a_first_cycle: assert property (@(posedge clk)
    $rose(arst_n) |-> !out_valid && !in_ready)
    else begin
      failures++;
      $error("handshake outputs active on the first cycle after reset");
    end

  a_ready_rise: assert property (@(posedge clk)
    $rose(arst_n) |=> in_ready)
    else begin
      failures++;
      $error("in_ready did not rise after the first cycle");
    end

endmodule

bind approx_div_top approx_div_sva i_approx_div_sva (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .n         (n),
  .d         (d),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .q         (q),
  .r         (r),
  .ovf       (ovf)
);

// ==== verif/approx_div_tb.sv ====
`timescale 1ns/1ps

module approx_div_tb;
  import div_pkg::*;
  import cfg_pkg::*;

  localparam int depth = 6;
  localparam int ops_per_mode = 100;
  localparam int cycle_limit = 4 * 2 * ops_per_mode + 200;

  logic                  clk;
  logic                  arst_n;
  logic                  in_valid;
  logic                  in_ready;
  logic [n_width-1:0]    op_n;
  logic [d_width-1:0]    op_d;
  logic                  out_valid;
  logic                  out_ready;
  logic [d_width-1:0]    q;
  logic [d_width-1:0]    r;
  logic                  ovf;
  logic                  cfg_wr;
  logic                  cfg_rd;
  logic [addr_width-1:0] cfg_addr;
  logic [cnt_width-1:0]  cfg_wdata;
  logic [cnt_width-1:0]  cfg_rdata;

  logic                  cur_mode;
  logic [24:0]           pending [$];
  bit                    ready_pattern [1024];
  int                    cycles = 0;
  int                    errors = 0;
  int                    exp_ops = 0;
  int                    exp_ovf = 0;
  int                    exp_mism = 0;

  clk_gen i_clk_gen (.clk(clk));

  approx_div_top #(.approx_depth(depth)) i_approx_div_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .n         (op_n),
    .d         (op_d),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .q         (q),
    .r         (r),
    .ovf       (ovf),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  function automatic void report_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endfunction

  // Cell level restoring array with approximate cells where row plus column is below dep
  function automatic logic [15:0] array_model(input logic [15:0] nn, input logic [7:0] dd,
                                              input int dep);
    logic [7:0] rem;
    logic [7:0] x;
    logic [7:0] diff;
    logic [7:0] qv;
    logic       top;
    logic       b;
    rem = '0;
    for (int k = 7; k >= 0; k--) begin
      x = (k == 7) ? nn[14:7] : {rem[6:0], nn[k]};
      top = (k == 7) ? nn[15] : rem[7];
      b = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (k + j < dep) begin
          diff[j] = (x[j] & ~dd[j] & ~b) | (x[j] & dd[j] & b);
          b = (~x[j] & dd[j]) | (x[j] & dd[j] & b);
        end else begin
          diff[j] = x[j] ^ dd[j] ^ b;
          b = (~x[j] & dd[j]) | (~(x[j] ^ dd[j]) & b);
        end
      end
      qv[k] = top | ~b;
      rem = qv[k] ? diff : x;
    end
    return {qv, rem};
  endfunction

  task automatic check_output(input logic [24:0] item);
    logic               mode;
    logic [n_width-1:0] nn;
    logic [d_width-1:0] dd;
    logic [d_width-1:0] eq;
    logic [d_width-1:0] er;
    logic [15:0]        model;
    {mode, nn, dd} = item;
    model = array_model(nn, dd, depth);
    exp_ops++;
    if (dd == 0 || nn / dd > 16'h00ff) begin
      exp_ovf++;
      assert (ovf && q == 8'hff && r == 8'h00)
        else report_error($sformatf("n=%h d=%h expected overflow, got ovf=%b q=%h r=%h",
                                    nn, dd, ovf, q, r));
    end else begin
      eq = nn / dd;
      er = nn % dd;
      if (model != {eq, er}) exp_mism++;
      if (mode == mode_approx) begin
        assert (!ovf && {q, r} == model)
          else report_error($sformatf("approx n=%h d=%h got q=%h r=%h ovf=%b, expected %h %h",
                                      nn, dd, q, r, ovf, model[15:8], model[7:0]));
      end else begin
        assert (!ovf && q == eq && r == er)
          else report_error($sformatf("exact n=%h d=%h got q=%h r=%h ovf=%b, expected %h %h",
                                      nn, dd, q, r, ovf, eq, er));
      end
    end
  endtask

  // Transfers are seen at the falling edge before the rising edge that takes them
  always @(negedge clk) begin
    if (arst_n && out_valid && out_ready) begin
      assert (pending.size() > 0)
        else report_error("output transfer with no pending input");
      if (pending.size() > 0) check_output(pending.pop_front());
    end
    if (arst_n && in_valid && in_ready) pending.push_back({cur_mode, op_n, op_d});
  end

  always @(posedge clk) begin
    out_ready <= ready_pattern[cycles % 1024];
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped moving data", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic run_ops(input int count);
    logic [7:0] dd;
    logic [7:0] hi;
    for (int i = 0; i < count; i++) begin
      case ($urandom % 8)
        0: begin
          dd = '0;
          hi = $urandom;
        end
        1: begin
          dd = $urandom_range(255, 1);
          hi = $urandom_range(255, dd);
        end
        default: begin
          dd = $urandom_range(255, 1);
          hi = $urandom % dd;
        end
      endcase
      @(posedge clk);
      in_valid <= 1'b1;
      op_d <= dd;
      op_n <= {hi, 8'($urandom)};
      do @(negedge clk); while (!in_ready);
      if ($urandom % 4 == 0) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    while (pending.size() != 0 || out_valid) @(negedge clk);
    repeat (3) @(posedge clk);
  endtask

  task automatic write_reg(input logic [addr_width-1:0] addr, input logic [cnt_width-1:0] data);
    @(posedge clk);
    cfg_wr <= 1'b1;
    cfg_addr <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr <= 1'b0;
  endtask

  task automatic check_reg(input logic [addr_width-1:0] addr, input int expected,
                           input string name);
    @(posedge clk);
    cfg_rd <= 1'b1;
    cfg_addr <= addr;
    @(posedge clk);
    cfg_rd <= 1'b0;
    @(negedge clk);
    assert (cfg_rdata == expected)
      else report_error($sformatf("%s read %0d, expected %0d", name, cfg_rdata, expected));
  endtask

  initial begin
    void'($urandom(32'h8fa2));
    foreach (ready_pattern[i]) ready_pattern[i] = ($urandom % 4) != 0;
    arst_n = 1'b0;
    in_valid = 1'b0;
    op_n = '0;
    op_d = '0;
    out_ready = 1'b0;
    cfg_wr = 1'b0;
    cfg_rd = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    cur_mode = mode_exact;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    run_ops(ops_per_mode);
    wait_drain();
    write_reg(addr_mode, 16'(mode_approx));
    cur_mode = mode_approx;
    run_ops(ops_per_mode);
    wait_drain();
    check_reg(addr_mode, 1, "mode register");
    check_reg(addr_op_count, exp_ops, "operation counter");
    check_reg(addr_ovf_count, exp_ovf, "overflow counter");
    check_reg(addr_mismatch_count, exp_mism, "mismatch counter");
    for (int a = 1; a < 4; a++) begin
      write_reg(a, '0);
      check_reg(a, 0, "cleared counter");
    end
    // Bound assertion failures count as errors too
    errors += i_approx_div_top.i_approx_div_sva.failures;
    $display("errors %0d, operations %0d, overflows %0d, mismatches %0d",
             errors, exp_ops, exp_ovf, exp_mism);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
common/div_pkg.sv
common/cfg_pkg.sv
common/div_stat_if.sv
approx_divider/approx_div_cells.sv
approx_divider/divider_array_triangular.sv
verilog/div_pipe.sv
verilog/div_cfg_regs.sv
verilog/approx_div_top.sv
verif/clk_gen.sv
verif/approx_div_sva.sv
verif/approx_div_tb.sv
